// File: boot_pkg.sv
`default_nettype none

package boot_pkg;

	////////////////////////////////////////
	// Data widths
	////////////////////////////////////////

	// One serial data byte
	typedef logic [7:0] byte_t;

	// Instruction word and AXI data
	typedef logic [31:0] word_t;

	// Byte address on both ports
	typedef logic [31:0] addr_t;

	////////////////////////////////////////
	// State machines
	////////////////////////////////////////

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// Which byte of the word comes next
	typedef enum logic [1:0] {
		phase_first,
		phase_second,
		phase_third,
		phase_fourth
	} byte_phase_t;

	////////////////////////////////////////
	// AXI response codes
	////////////////////////////////////////

	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx import boot_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
)
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	output byte_t rx_byte,
	output logic  rx_byte_valid
);

	localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

	// Counter end values
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift;
	logic             sample_data;
	logic             sample_stop;

	////////////////////////////////////////
	// Input synchronizer
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Middle of a data bit or of the stop bit
	assign sample_data = (state == rx_data) && (bit_cnt == FULL_BIT);
	assign sample_stop = (state == rx_stop) && (bit_cnt == FULL_BIT);

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state         <= rx_idle;
			bit_cnt       <= '0;
			bit_idx       <= '0;
			rx_byte_valid <= 1'b0;
		end
		else
		begin
			rx_byte_valid <= 1'b0;
			case (state)
				rx_idle:
				begin
					bit_cnt <= '0;
					bit_idx <= '0;
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start:
				begin
					if (bit_cnt == HALF_BIT)
					begin
						bit_cnt <= '0;
						// Line went high again, so it was a glitch
						state <= rx_sync ? rx_idle : rx_data;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				rx_data:
				begin
					if (sample_data)
					begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				rx_stop:
				begin
					if (sample_stop)
					begin
						// Framing error drops the byte
						rx_byte_valid <= rx_sync;
						state         <= rx_idle;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default:
					state <= rx_idle;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (sample_data)
			shift <= {rx_sync, shift[7:1]};
		if (sample_stop)
			rx_byte <= shift;
	end

	a_valid_single: assert property (@(posedge clk) disable iff (reset)
		rx_byte_valid |=> !rx_byte_valid);

endmodule

`default_nettype wire

// File: word_assembler.sv
`default_nettype none

module word_assembler import boot_pkg::*;
#(
	parameter int MEM_DEPTH = 16
)
(
	input  logic        clk,
	input  logic        reset,
	input  byte_t       rx_byte,
	input  logic        rx_byte_valid,
	output logic        wr_en,
	output addr_t       wr_addr,
	output word_t       wr_word,
	output logic [15:0] loaded_words
);

	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(MEM_DEPTH - 1);

	byte_phase_t      phase;
	logic [IDX_W-1:0] word_idx;

	// Word index to byte address
	assign wr_addr = addr_t'({word_idx, 2'b00});

	////////////////////////////////////////
	// Byte phase and load pointer
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			phase        <= phase_first;
			wr_en        <= 1'b0;
			word_idx     <= '0;
			loaded_words <= '0;
		end
		else
		begin
			wr_en <= rx_byte_valid && (phase == phase_fourth);
			if (rx_byte_valid)
			begin
				case (phase)
					phase_first:  phase <= phase_second;
					phase_second: phase <= phase_third;
					phase_third:  phase <= phase_fourth;
					default:      phase <= phase_first;
				endcase
			end
			// Move on once the word has gone out
			if (wr_en)
			begin
				word_idx     <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;
				loaded_words <= loaded_words + 16'd1;
			end
		end
	end

	// First byte lands in the top lane
	always_ff @(posedge clk)
	begin
		if (rx_byte_valid)
		begin
			case (phase)
				phase_first:  wr_word[31:24] <= rx_byte;
				phase_second: wr_word[23:16] <= rx_byte;
				phase_third:  wr_word[15:8]  <= rx_byte;
				default:      wr_word[7:0]   <= rx_byte;
			endcase
		end
	end

	a_addr_range: assert property (@(posedge clk) disable iff (reset)
		wr_addr < addr_t'(MEM_DEPTH * 4) && wr_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: instr_mem.sv
`default_nettype none

module instr_mem import boot_pkg::*;
#(
	parameter int MEM_DEPTH = 16
)
(
	input  logic  clk,
	input  logic  reset,
	input  logic  wr_en,
	input  addr_t wr_addr,
	input  word_t wr_word,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output word_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready
);

	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	word_t            mem [MEM_DEPTH];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic             rd_in_range;
	logic             ar_hs;

	// Low two address bits are ignored
	assign wr_idx      = wr_addr[IDX_W+1:2];
	assign rd_idx      = araddr[IDX_W+1:2];
	assign rd_in_range = araddr[31:2] < 30'(MEM_DEPTH);

	// Only one response in flight
	assign arready = !rvalid;
	assign ar_hs   = arvalid && arready;

	////////////////////////////////////////
	// Loader write port
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_en)
			mem[wr_idx] <= wr_word;
	end

	////////////////////////////////////////
	// AXI4-Lite read slave
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// Old word wins on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (ar_hs)
		begin
			if (rd_in_range)
			begin
				rdata <= mem[rd_idx];
				rresp <= resp_okay;
			end
			else
			begin
				rdata <= '0;
				rresp <= resp_slverr;
			end
		end
	end

	a_r_stable: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: uart_boot_loader.sv
`default_nettype none

module uart_boot_loader import boot_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8,
	parameter int MEM_DEPTH    = 16
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        rx,
	output logic [15:0] loaded_words,
	input  addr_t       araddr,
	input  logic        arvalid,
	output logic        arready,
	output word_t       rdata,
	output resp_t       rresp,
	output logic        rvalid,
	input  logic        rready
);

	byte_t rx_byte;
	logic  rx_byte_valid;
	logic  wr_en;
	addr_t wr_addr;
	word_t wr_word;

	// Serial line to bytes
	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.clk           (clk),
		.reset         (reset),
		.rx            (rx),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	// Bytes to words at the next load address
	word_assembler #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_word_assembler (
		.clk           (clk),
		.reset         (reset),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_word       (wr_word),
		.loaded_words  (loaded_words)
	);

	instr_mem #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_instr_mem (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_word (wr_word),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

endmodule

`default_nettype wire

// File: boot_checker.sv
`default_nettype none

module boot_checker import boot_pkg::*;
#(
	parameter int MEM_DEPTH = 16
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] loaded_words,
	input  addr_t       araddr,
	input  logic        arvalid,
	input  logic        arready,
	input  word_t       rdata,
	input  resp_t       rresp,
	input  logic        rvalid,
	input  logic        rready,
	input  logic        note_valid,
	input  byte_t       note_byte,
	input  logic        count_check,
	input  int          test_num,
	input  logic        all_done,
	output int          checks,
	output int          errors
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	// Model of the loaded program
	word_t            model [MEM_DEPTH];
	logic [IDX_W-1:0] model_idx;
	int               model_count;
	word_t            partial;
	int               byte_cnt;

	word_t exp_data;
	resp_t exp_resp;
	logic  hold_prev;
	word_t held_data;
	resp_t held_resp;
	logic  after_reset;
	logic  done_seen = 1'b0;
	int    prev_test = 0;
	int    test_checks = 0;
	int    test_errors = 0;
	int    check_total = 0;
	int    err_total = 0;

	assign checks = check_total;
	assign errors = err_total;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic word_t expected_word(input addr_t addr);
		if (addr[31:2] >= 30'(MEM_DEPTH))
			return '0;
		return model[addr[IDX_W+1:2]];
	endfunction

	function automatic resp_t expected_resp(input addr_t addr);
		return (addr[31:2] >= 30'(MEM_DEPTH)) ? resp_slverr : resp_okay;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "byte order";
			3: return "twenty words with wrap";
			4: return "framing error";
			5: return "read back-pressure";
			6: return "out of range read";
			default: return "unnamed";
		endcase
	endfunction

	task automatic flag_mismatch(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		err_total++;
		test_errors++;
	endtask

	task automatic count_check_done();
		check_total++;
		test_checks++;
	endtask

	////////////////////////////////////////
	// Compare process on the falling edge
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < MEM_DEPTH; i++)
				model[i] = '0;
			model_idx   = '0;
			model_count = 0;
			partial     = '0;
			byte_cnt    = 0;
			hold_prev   = 1'b0;
			after_reset = 1'b1;
		end
		else
		begin
			if (test_num != prev_test)
			begin
				if (prev_test != 0)
					$display("test %0d (%s): %0d checks, %0d errors, %s", prev_test,
						test_name(prev_test), test_checks, test_errors,
						(test_errors == 0) ? "passed" : "failed");
				prev_test   = test_num;
				test_checks = 0;
				test_errors = 0;
			end
			if (after_reset)
			begin
				count_check_done();
				if (rvalid || !arready || loaded_words != 16'd0)
					flag_mismatch("outputs not in their reset state");
			end
			after_reset = 1'b0;
			// Held response must not move before rready
			if (hold_prev && (!rvalid || rdata != held_data || rresp != held_resp))
				flag_mismatch($sformatf(
					"R channel changed under back-pressure, rdata %h rresp %0d",
					rdata, rresp));
			if (rvalid && arready)
				flag_mismatch("arready high while a response is pending");
			hold_prev = rvalid && !rready;
			held_data = rdata;
			held_resp = rresp;
			if (rvalid && rready)
			begin
				count_check_done();
				if (rdata !== exp_data || rresp !== exp_resp)
					flag_mismatch($sformatf("read got %h resp %0d, expected %h resp %0d",
						rdata, rresp, exp_data, exp_resp));
			end
			if (arvalid && arready)
			begin
				exp_data = expected_word(araddr);
				exp_resp = expected_resp(araddr);
			end
			// First byte ends up in the top lane
			if (note_valid)
			begin
				partial = {partial[23:0], note_byte};
				if (byte_cnt == 3)
				begin
					model[model_idx] = partial;
					model_idx   = (model_idx == IDX_W'(MEM_DEPTH - 1)) ? '0 : model_idx + 1'b1;
					model_count = model_count + 1;
					byte_cnt    = 0;
				end
				else
					byte_cnt = byte_cnt + 1;
			end
			if (count_check)
			begin
				count_check_done();
				if (loaded_words !== 16'(model_count))
					flag_mismatch($sformatf("loaded_words %0d, expected %0d",
						loaded_words, model_count));
			end
			if (all_done && !done_seen)
			begin
				$display("total: %0d checks, %0d errors", check_total, err_total);
				done_seen = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_uart_boot.sv
`default_nettype none

module tb_uart_boot import boot_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLKS_PER_BIT = 8;
	localparam int MEM_DEPTH    = 16;
	// About 22 words of 40 bit periods at 8 cycles plus reads and margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk;
	logic        reset;
	logic        rx;
	logic [15:0] loaded_words;
	addr_t       araddr;
	logic        arvalid;
	logic        arready;
	word_t       rdata;
	resp_t       rresp;
	logic        rvalid;
	logic        rready;
	logic        note_valid;
	byte_t       note_byte;
	logic        count_check;
	int          test_num;
	logic        all_done;
	int          checks;
	int          errors;
	int          words_sent;
	int          cycles = 0;
	logic [31:0] lfsr = 32'hd425_77b5;

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Run timed out after %0d cycles without finishing the tests", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic byte_t rand_bits(input int n);
		byte_t r;
		logic  fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[6:0], fb};
		end
		return r;
	endfunction

	// n rising edges, then the 1 ns drive point
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		step(3);
		reset = 1'b0;
	endtask

	task automatic send_frame(input byte_t b, input logic stop_bit);
		rx = 1'b0;
		step(CLKS_PER_BIT);
		for (int i = 0; i < 8; i++)
		begin
			rx = b[i];
			step(CLKS_PER_BIT);
		end
		rx = stop_bit;
		step(CLKS_PER_BIT);
		rx = 1'b1;
		step(CLKS_PER_BIT);
	endtask

	// Good frame, then tell the checker about the byte
	task automatic send_random_word();
		byte_t b;
		for (int i = 0; i < 4; i++)
		begin
			b = rand_bits(8);
			send_frame(b, 1'b1);
			note_byte  = b;
			note_valid = 1'b1;
			step(1);
			note_valid = 1'b0;
		end
		words_sent++;
	endtask

	task automatic wait_loaded(input int target);
		int n;
		n = 0;
		while (loaded_words != 16'(target) && n < 4 * CLKS_PER_BIT)
		begin
			step(1);
			n++;
		end
		count_check = 1'b1;
		step(1);
		count_check = 1'b0;
	endtask

	task automatic axi_read(input addr_t addr);
		int delay;
		delay   = int'(rand_bits(2));
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready)
			step(1);
		step(1);
		arvalid = 1'b0;
		while (!rvalid)
			step(1);
		repeat (delay)
			step(1);
		rready = 1'b1;
		step(1);
		rready = 1'b0;
	endtask

	uart_boot_loader #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MEM_DEPTH    (MEM_DEPTH)
	) u_dut (
		.clk          (clk),
		.reset        (reset),
		.rx           (rx),
		.loaded_words (loaded_words),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready)
	);

	boot_checker #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_checker (
		.clk          (clk),
		.reset        (reset),
		.loaded_words (loaded_words),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.note_valid   (note_valid),
		.note_byte    (note_byte),
		.count_check  (count_check),
		.test_num     (test_num),
		.all_done     (all_done),
		.checks       (checks),
		.errors       (errors)
	);

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		addr_t a;
		rx          = 1'b1;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		note_valid  = 1'b0;
		note_byte   = '0;
		count_check = 1'b0;
		test_num    = 0;
		all_done    = 1'b0;
		words_sent  = 0;
		apply_reset();

		test_num = 1;
		wait_loaded(0);
		for (int i = 0; i < MEM_DEPTH; i++)
			axi_read(addr_t'(i * 4));

		test_num = 2;
		send_random_word();
		wait_loaded(words_sent);
		axi_read(32'h0);

		// Fresh start so the twenty words begin at address 0
		test_num = 3;
		apply_reset();
		words_sent = 0;
		for (int i = 0; i < 20; i++)
			send_random_word();
		wait_loaded(words_sent);
		for (int i = 0; i < MEM_DEPTH; i++)
			axi_read(addr_t'(i * 4));

		test_num = 4;
		send_frame(rand_bits(8), 1'b0);
		wait_loaded(words_sent);
		send_random_word();
		wait_loaded(words_sent);
		// Word 20 lands at index 4
		axi_read(32'h10);

		// Low address bits are random too since the memory ignores them
		test_num = 5;
		for (int i = 0; i < 12; i++)
		begin
			a = addr_t'(rand_bits(4)) << 2;
			a = a | addr_t'(rand_bits(2));
			axi_read(a);
		end

		test_num = 6;
		axi_read(32'h40);
		axi_read(32'h47);
		axi_read(32'h0000_0400);
		axi_read(32'hffff_fffc);

		test_num = 7;
		step(1);
		all_done = 1'b1;
		step(2);
		if (errors == 0 && checks > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
boot_pkg.sv
uart_rx.sv
word_assembler.sv
instr_mem.sv
uart_boot_loader.sv
boot_checker.sv
tb_uart_boot.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_uart_boot
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
